/* src/nox_params.svh */
// Global sizes shared by every unit; scratchpad depth must be a power of two
`default_nettype none
`ifndef NOX_PARAMS_SVH
`define NOX_PARAMS_SVH

// Datapath and tag sizes
`define NOX_XLEN        32
`define NOX_TAG_W       4
`define NOX_RD_W        5
// LSU scratchpad depth in words and immediate offset width
`define NOX_DMEM_WORDS  16
`define NOX_OFS_W       12

`endif
`default_nettype wire

/* src/nox_pkg.sv */
// Shared types; widths follow nox_params.svh and do not vary per instance
`include "nox_params.svh"
`default_nettype none

package nox_pkg;

  // Execution unit that takes the packet
  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_LSU = 1'b1
  } unit_e;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_e;

  typedef enum logic {
    LSU_LOAD  = 1'b0,
    LSU_STORE = 1'b1
  } lsu_op_e;

  // Issue packet, operands already resolved to values
  typedef struct packed {
    unit_e                        unit;
    logic [`NOX_TAG_W-1:0]        tag;
    logic [`NOX_RD_W-1:0]         rd;
    alu_op_e                      alu_op;
    lsu_op_e                      lsu_op;
    logic [`NOX_XLEN-1:0]         rs1;
    logic [`NOX_XLEN-1:0]         rs2;
    logic signed [`NOX_OFS_W-1:0] ofs;
  } s_issue_t;

  // Write-back result, wr_en low for stores
  typedef struct packed {
    logic [`NOX_TAG_W-1:0] tag;
    logic [`NOX_RD_W-1:0]  rd;
    logic                  wr_en;
    logic [`NOX_XLEN-1:0]  data;
  } s_result_t;

endpackage

`default_nettype wire

/* src/alu_unit.sv */
// Single-cycle ALU with one result register; input stalls while a held result waits
`timescale 1ns/1ps
`include "nox_params.svh"
`default_nettype none

module alu_unit (
  input  logic               clk,
  input  logic               rst_n_i,
  // Issue side
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  nox_pkg::s_issue_t  in_i,
  // Result side
  output logic               res_valid_o,
  input  logic               res_ready_i,
  output nox_pkg::s_result_t res_o
);
  logic                          accept;
  logic [$clog2(`NOX_XLEN)-1:0] shamt;
  logic                          lt_signed;
  logic [`NOX_XLEN-1:0]          alu_data;
  nox_pkg::s_result_t            res_next;
  nox_pkg::s_result_t            res_ff;
  logic                          res_valid_ff;

  // Free when empty or when the held result leaves this cycle
  assign in_ready_o = ~res_valid_ff | res_ready_i;
  assign accept     = in_valid_i & in_ready_o;

  // Only the low bits of rs2 count as shift amount
  assign shamt     = in_i.rs2[$clog2(`NOX_XLEN)-1:0];
  assign lt_signed = $signed(in_i.rs1) < $signed(in_i.rs2);

  always_comb begin
    case (in_i.alu_op)
      nox_pkg::ALU_ADD: alu_data = in_i.rs1 + in_i.rs2;
      nox_pkg::ALU_SUB: alu_data = in_i.rs1 - in_i.rs2;
      nox_pkg::ALU_AND: alu_data = in_i.rs1 & in_i.rs2;
      nox_pkg::ALU_OR:  alu_data = in_i.rs1 | in_i.rs2;
      nox_pkg::ALU_XOR: alu_data = in_i.rs1 ^ in_i.rs2;
      nox_pkg::ALU_SLL: alu_data = in_i.rs1 << shamt;
      nox_pkg::ALU_SRL: alu_data = in_i.rs1 >> shamt;
      nox_pkg::ALU_SLT: alu_data = {{(`NOX_XLEN-1){1'b0}}, lt_signed};
      default:          alu_data = '0;
    endcase
  end

  always_comb begin
    res_next.tag   = in_i.tag;
    res_next.rd    = in_i.rd;
    res_next.wr_en = 1'b1;
    res_next.data  = alu_data;
  end

  // Result payload
  always_ff @(posedge clk) begin
    if (accept) begin
      res_ff <= res_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_ff <= 1'b0;
    end else if (accept) begin
      res_valid_ff <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_ff <= 1'b0;
    end
  end

  assign res_valid_o = res_valid_ff;
  assign res_o       = res_ff;

endmodule

`default_nettype wire

/* src/lsu_unit.sv */
// Word-only LSU on a local scratchpad; byte offsets ignored and the address wraps at the depth
`timescale 1ns/1ps
`include "nox_params.svh"
`default_nettype none

module lsu_unit (
  input  logic               clk,
  input  logic               rst_n_i,
  // Issue side
  input  logic               in_valid_i,
  output logic               in_ready_o,
  input  nox_pkg::s_issue_t  in_i,
  // Result side
  output logic               res_valid_o,
  input  logic               res_ready_i,
  output nox_pkg::s_result_t res_o
);
  logic                                accept;
  logic                                is_store;
  logic [`NOX_XLEN-1:0]                ofs_ext;
  logic [`NOX_XLEN-1:0]                byte_addr;
  logic [$clog2(`NOX_DMEM_WORDS)-1:0] word_idx;
  logic [`NOX_XLEN-1:0]                dmem [`NOX_DMEM_WORDS];
  nox_pkg::s_result_t                  res_next;
  nox_pkg::s_result_t                  res_ff;
  logic                                res_valid_ff;

  assign in_ready_o = ~res_valid_ff | res_ready_i;
  assign accept     = in_valid_i & in_ready_o;
  assign is_store   = (in_i.lsu_op == nox_pkg::LSU_STORE);

  // Effective address, word index taken above the byte bits
  assign ofs_ext   = {{(`NOX_XLEN-`NOX_OFS_W){in_i.ofs[`NOX_OFS_W-1]}}, in_i.ofs};
  assign byte_addr = in_i.rs1 + ofs_ext;
  assign word_idx  = byte_addr[2 +: $clog2(`NOX_DMEM_WORDS)];

  // Scratchpad starts out cleared
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `NOX_DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (accept && is_store) begin
      dmem[word_idx] <= in_i.rs2;
    end
  end

  // Load sees memory as it stands before this edge
  always_comb begin
    res_next.tag = in_i.tag;
    res_next.rd  = in_i.rd;
    if (is_store) begin
      res_next.wr_en = 1'b0;
      res_next.data  = '0;
    end else begin
      res_next.wr_en = 1'b1;
      res_next.data  = dmem[word_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_ff <= res_next;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_ff <= 1'b0;
    end else if (accept) begin
      res_valid_ff <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_ff <= 1'b0;
    end
  end

  assign res_valid_o = res_valid_ff;
  assign res_o       = res_ff;

endmodule

`default_nettype wire

/* src/wb_merge.sv */
// Fixed-priority merge, LSU always wins; a steady LSU stream can starve the ALU
`timescale 1ns/1ps
`default_nettype none

module wb_merge (
  input  logic               clk,
  input  logic               rst_n_i,
  // ALU result stream
  input  logic               alu_valid_i,
  output logic               alu_ready_o,
  input  nox_pkg::s_result_t alu_i,
  // LSU result stream
  input  logic               lsu_valid_i,
  output logic               lsu_ready_o,
  input  nox_pkg::s_result_t lsu_i,
  // Write-back output
  output logic               wb_valid_o,
  input  logic               wb_ready_i,
  output nox_pkg::s_result_t wb_o
);
  logic               out_free;
  logic               take;
  nox_pkg::s_result_t sel;
  nox_pkg::s_result_t wb_ff;
  logic               wb_valid_ff;

  assign out_free = ~wb_valid_ff | wb_ready_i;

  // Ready only to the selected source
  assign lsu_ready_o = out_free;
  assign alu_ready_o = out_free & ~lsu_valid_i;

  assign sel  = lsu_valid_i ? lsu_i : alu_i;
  assign take = out_free & (lsu_valid_i | alu_valid_i);

  always_ff @(posedge clk) begin
    if (take) begin
      wb_ff <= sel;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_ff <= 1'b0;
    end else if (take) begin
      wb_valid_ff <= 1'b1;
    end else if (wb_ready_i) begin
      wb_valid_ff <= 1'b0;
    end
  end

  assign wb_valid_o = wb_valid_ff;
  assign wb_o       = wb_ff;

endmodule

`default_nettype wire

/* src/nox_exec.sv */
// Back end only; operands arrive as values, no traps, results may return out of issue order
`timescale 1ns/1ps
`default_nettype none

module nox_exec (
  input  logic               clk,
  input  logic               rst_n_i,
  // Issue port
  input  logic               issue_valid_i,
  output logic               issue_ready_o,
  input  nox_pkg::s_issue_t  issue_i,
  // Write-back port
  output logic               wb_valid_o,
  input  logic               wb_ready_i,
  output nox_pkg::s_result_t wb_o
);
  logic               alu_valid;
  logic               alu_ready;
  logic               lsu_valid;
  logic               lsu_ready;
  logic               alu_res_valid;
  logic               alu_res_ready;
  nox_pkg::s_result_t alu_res;
  logic               lsu_res_valid;
  logic               lsu_res_ready;
  nox_pkg::s_result_t lsu_res;

  // Steer by unit field
  assign alu_valid     = issue_valid_i & (issue_i.unit == nox_pkg::UNIT_ALU);
  assign lsu_valid     = issue_valid_i & (issue_i.unit == nox_pkg::UNIT_LSU);
  assign issue_ready_o = (issue_i.unit == nox_pkg::UNIT_LSU) ? lsu_ready : alu_ready;

  alu_unit u_alu_unit (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (alu_valid),
    .in_ready_o  (alu_ready),
    .in_i        (issue_i),
    .res_valid_o (alu_res_valid),
    .res_ready_i (alu_res_ready),
    .res_o       (alu_res)
  );

  lsu_unit u_lsu_unit (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (lsu_valid),
    .in_ready_o  (lsu_ready),
    .in_i        (issue_i),
    .res_valid_o (lsu_res_valid),
    .res_ready_i (lsu_res_ready),
    .res_o       (lsu_res)
  );

  // Both paths join here
  wb_merge u_wb_merge (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .alu_valid_i (alu_res_valid),
    .alu_ready_o (alu_res_ready),
    .alu_i       (alu_res),
    .lsu_valid_i (lsu_res_valid),
    .lsu_ready_o (lsu_res_ready),
    .lsu_i       (lsu_res),
    .wb_valid_o  (wb_valid_o),
    .wb_ready_i  (wb_ready_i),
    .wb_o        (wb_o)
  );

endmodule

`default_nettype wire

/* verification/nox_exec_chk.sv */
// Handshake checks for nox_exec; assumes both ports follow the valid/ready hold rule
`timescale 1ns/1ps
`default_nettype none

module nox_exec_chk (
  input logic               clk,
  input logic               rst_n_i,
  input logic               issue_valid_i,
  input logic               issue_ready_o,
  input nox_pkg::s_issue_t  issue_i,
  input logic               wb_valid_o,
  input logic               wb_ready_i,
  input nox_pkg::s_result_t wb_o
);

  // Producer side holds a stalled packet
  a_issue_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    (issue_valid_i && !issue_ready_o) |=> (issue_valid_i && $stable(issue_i)))
    else $error("issue_i changed while stalled");

  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wb_valid_o && !wb_ready_i) |=> $stable(wb_o))
    else $error("wb_o changed while stalled");

  a_wb_keep: assert property (@(posedge clk) disable iff (!rst_n_i)
    (wb_valid_o && !wb_ready_i) |=> wb_valid_o)
    else $error("wb_valid_o dropped without a handshake");

  a_wb_reset: assert property (@(posedge clk) !rst_n_i |-> !wb_valid_o)
    else $error("wb_valid_o high during reset");

endmodule

bind nox_exec nox_exec_chk nox_exec_chk_inst (
  .clk           (clk),
  .rst_n_i       (rst_n_i),
  .issue_valid_i (issue_valid_i),
  .issue_ready_o (issue_ready_o),
  .issue_i       (issue_i),
  .wb_valid_o    (wb_valid_o),
  .wb_ready_i    (wb_ready_i),
  .wb_o          (wb_o)
);

`default_nettype wire

/* verification/tb_nox_exec.sv */
// Random test of nox_exec; every tag stays unique until its write-back, scratchpad starts at zero
`timescale 1ns/1ps
`include "nox_params.svh"
`default_nettype none

module tb_nox_exec;
  localparam int NUM_PKTS    = 600;
  localparam int CLK_HALF    = 4;
  localparam int TAGS        = 2 ** `NOX_TAG_W;
  localparam int IDX_W       = $clog2(`NOX_DMEM_WORDS);
  // Worst case per packet with back-pressure, plus margin for drain
  localparam int WORST_CYC   = 12;
  localparam int WATCHDOG_NS = (NUM_PKTS * WORST_CYC + 200) * 2 * CLK_HALF;

  logic               clk;
  logic               rst_n_i;
  logic               issue_valid_i;
  logic               issue_ready_o;
  nox_pkg::s_issue_t  issue_i;
  logic               wb_valid_o;
  logic               wb_ready_i;
  nox_pkg::s_result_t wb_o;

  logic [31:0]          rng;
  logic [`NOX_XLEN-1:0] mem_model [`NOX_DMEM_WORDS];
  nox_pkg::s_result_t   exp_res [TAGS];
  logic                 exp_live [TAGS];
  logic                 tag_busy [TAGS];
  int                   sent;
  int                   retired;
  int                   mismatch_cnt;
  int                   proto_cnt;
  int                   timeout_cnt;

  nox_exec nox_exec_inst (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_i       (issue_i),
    .wb_valid_o    (wb_valid_o),
    .wb_ready_i    (wb_ready_i),
    .wb_o          (wb_o)
  );

  always #CLK_HALF clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic logic [`NOX_XLEN-1:0] alu_expect(input nox_pkg::alu_op_e op,
                                                      input logic [`NOX_XLEN-1:0] a,
                                                      input logic [`NOX_XLEN-1:0] b);
    case (op)
      nox_pkg::ALU_ADD: return a + b;
      nox_pkg::ALU_SUB: return a - b;
      nox_pkg::ALU_AND: return a & b;
      nox_pkg::ALU_OR:  return a | b;
      nox_pkg::ALU_XOR: return a ^ b;
      nox_pkg::ALU_SLL: return a << b[4:0];
      nox_pkg::ALU_SRL: return a >> b[4:0];
      default:          return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  // Byte address, then drop the two byte bits and wrap at the depth
  function automatic logic [IDX_W-1:0] word_index(input logic [`NOX_XLEN-1:0] base,
                                                  input logic [`NOX_OFS_W-1:0] ofs);
    logic [`NOX_XLEN-1:0] addr;
    addr = base + {{(`NOX_XLEN-`NOX_OFS_W){ofs[`NOX_OFS_W-1]}}, ofs};
    return addr[2 +: IDX_W];
  endfunction

  // Runs in issue order, so stores land before any later load
  task automatic accept_model(input nox_pkg::s_issue_t p);
    nox_pkg::s_result_t want;
    logic [IDX_W-1:0]   idx;
    want.tag   = p.tag;
    want.rd    = p.rd;
    want.wr_en = 1'b1;
    want.data  = '0;
    if (p.unit == nox_pkg::UNIT_ALU) begin
      want.data = alu_expect(p.alu_op, p.rs1, p.rs2);
    end else begin
      idx = word_index(p.rs1, p.ofs);
      if (p.lsu_op == nox_pkg::LSU_STORE) begin
        want.wr_en     = 1'b0;
        mem_model[idx] = p.rs2;
      end else begin
        want.data = mem_model[idx];
      end
    end
    exp_res[p.tag]  = want;
    exp_live[p.tag] = 1'b1;
  endtask

  task automatic check_wb(input nox_pkg::s_result_t got);
    nox_pkg::s_result_t want;
    want = exp_res[got.tag];
    assert (exp_live[got.tag]) else begin
      $display("Write-back with tag %0d that is not outstanding", got.tag);
      proto_cnt++;
    end
    if (exp_live[got.tag]) begin
      assert (got.rd == want.rd) else begin
        $display("MISMATCH wb_o.rd tag %0h: got %0h expected %0h", got.tag, got.rd, want.rd);
        mismatch_cnt++;
      end
      assert (got.wr_en == want.wr_en) else begin
        $display("MISMATCH wb_o.wr_en tag %0h: got %0h expected %0h",
                 got.tag, got.wr_en, want.wr_en);
        mismatch_cnt++;
      end
      assert (got.data == want.data) else begin
        $display("MISMATCH wb_o.data tag %0h: got %h expected %h", got.tag, got.data, want.data);
        mismatch_cnt++;
      end
      exp_live[got.tag] = 1'b0;
      tag_busy[got.tag] = 1'b0;
      retired++;
    end
  endtask

  task automatic report_and_finish();
    $display("Errors: %0d mismatch, %0d protocol, %0d timeout (%0d of %0d retired)",
             mismatch_cnt, proto_cnt, timeout_cnt, retired, NUM_PKTS);
    if (mismatch_cnt + proto_cnt + timeout_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  endtask

  initial begin
    #WATCHDOG_NS;
    $display("Timeout: run did not retire all packets within %0d ns", WATCHDOG_NS);
    timeout_cnt++;
    report_and_finish();
  end

  initial begin
    nox_pkg::s_issue_t     pkt;
    logic [31:0]           r;
    logic [`NOX_TAG_W-1:0] cand;
    logic                  found;
    logic                  pending;
    clk           = 1'b0;
    rst_n_i       = 1'b0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    wb_ready_i    = 1'b0;
    rng           = 32'h4c142159;
    pending       = 1'b0;
    sent          = 0;
    retired       = 0;
    mismatch_cnt  = 0;
    proto_cnt     = 0;
    timeout_cnt   = 0;
    for (int i = 0; i < `NOX_DMEM_WORDS; i++) begin
      mem_model[i] = '0;
    end
    for (int i = 0; i < TAGS; i++) begin
      exp_live[i] = 1'b0;
      tag_busy[i] = 1'b0;
    end
    repeat (8) @(negedge clk);
    rst_n_i = 1'b1;
    #1;
    assert (!wb_valid_o && issue_ready_o) else begin
      $display("After reset wb_valid_o is not low or issue_ready_o is not high");
      proto_cnt++;
    end

    while (retired < NUM_PKTS) begin
      @(negedge clk);
      r = next_rand();
      // A new packet only once the previous one has been accepted
      if (!pending && sent < NUM_PKTS && r[1:0] != 2'b00) begin
        found = 1'b0;
        cand  = r[5:2];
        for (int k = 0; k < TAGS; k++) begin
          if (!found && !tag_busy[cand]) begin
            found = 1'b1;
            pkt.tag = cand;
          end
          cand = cand + 1'b1;
        end
        if (found) begin
          r          = next_rand();
          pkt.unit   = nox_pkg::unit_e'(r[0]);
          pkt.lsu_op = nox_pkg::lsu_op_e'(r[1]);
          pkt.alu_op = nox_pkg::alu_op_e'(r[4:2]);
          pkt.rd     = r[9:5];
          pkt.ofs    = {{5{r[16]}}, r[16:10]};
          // Mostly small bases so that word addresses repeat
          pkt.rs1    = r[17] ? next_rand() : (next_rand() & 32'h0000_007c);
          pkt.rs2    = next_rand();
          tag_busy[pkt.tag] = 1'b1;
          issue_i = pkt;
          pending = 1'b1;
          sent++;
        end
      end
      issue_valid_i = pending;
      wb_ready_i    = (next_rand() & 32'h3) != 32'h0;
      #1;
      if (issue_valid_i && issue_ready_o) begin
        accept_model(issue_i);
        pending = 1'b0;
      end
      if (wb_valid_o && wb_ready_i) begin
        check_wb(wb_o);
      end
    end

    // Nothing may come out once every packet is back
    repeat (4) begin
      @(negedge clk);
      issue_valid_i = 1'b0;
      wb_ready_i    = 1'b1;
      #1;
      assert (!wb_valid_o) else begin
        $display("Write-back with tag %0d after every packet was retired", wb_o.tag);
        proto_cnt++;
      end
    end
    report_and_finish();
  end

endmodule

`default_nettype wire

/* nox_exec.f */
+incdir+src
src/nox_pkg.sv
src/alu_unit.sv
src/lsu_unit.sv
src/wb_merge.sv
src/nox_exec.sv
verification/nox_exec_chk.sv
verification/tb_nox_exec.sv

/* run_sim.sh */
#!/bin/sh
# Builds and runs the nox_exec testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f nox_exec.f --top-module tb_nox_exec -o sim_nox_exec

status=0
./obj_dir/sim_nox_exec > sim.log 2>&1 || status=$?
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
  echo "Simulation reported failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi
echo "Simulation finished without failure"
